/* hdl/armPkg.sv */
package armPkg;

  // ============================================================
  // Vector types
  // ============================================================

  // Data, address and instruction word
  typedef logic [31:0] wordT;

  // Register index, r0 to r15
  typedef logic [3:0] regAddrT;

  // N Z C V from the MSB down
  typedef logic [3:0] flagsT;

  typedef logic [2:0] aluOpT;
  typedef logic [1:0] immSrcT;
  typedef logic [1:0] fwdSelT;

  // ============================================================
  // Encodings
  // ============================================================

  // ALU operations
  localparam aluOpT aluAdd = 3'd0;
  localparam aluOpT aluSub = 3'd1;
  localparam aluOpT aluAnd = 3'd2;
  localparam aluOpT aluOrr = 3'd3;
  localparam aluOpT aluEor = 3'd4;
  localparam aluOpT aluMov = 3'd5;

  // Immediate forms seen by the decode stage
  localparam immSrcT immData   = 2'd0;
  localparam immSrcT immMem    = 2'd1;
  localparam immSrcT immBranch = 2'd2;

  // Execute operand bypass sources
  localparam fwdSelT fwdNone    = 2'd0;
  localparam fwdSelT fwdResultW = 2'd1;
  localparam fwdSelT fwdAluOutM = 2'd2;

  // ============================================================
  // Sizes and constants
  // ============================================================
  localparam wordT        pcResetValue  = 32'h0000_0000;
  localparam wordT        pcStep        = 32'd4;
  localparam regAddrT     pcIndex       = 4'd15;
  localparam int unsigned memDepthWords = 64;

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic            clk,
  input  logic            we,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  armPkg::regAddrT wa,
  input  armPkg::wordT    wd,
  input  armPkg::wordT    pcValue,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);

  // Storage for r0 to r14 only
  armPkg::wordT regs [0:14];

  // Write at the edge, r15 is not real state
  always_ff @(posedge clk) begin
    if (we && (wa != armPkg::pcIndex)) begin
      regs[wa] <= wd;
    end
  end

  // Combinational reads
  // r15 returns the supplied PC value
  always_comb begin
    if (ra1 == armPkg::pcIndex) begin
      rd1 = pcValue;
    end else begin
      rd1 = regs[ra1];
    end
    if (ra2 == armPkg::pcIndex) begin
      rd2 = pcValue;
    end else begin
      rd2 = regs[ra2];
    end
  end

endmodule

/* hdl/immExtend.sv */
`timescale 1ns/1ps

module immExtend (
  input  armPkg::wordT   instr,
  input  armPkg::immSrcT immSrc,
  input  logic           signExtend,
  output armPkg::wordT   ext
);

  // Data-processing immediate
  logic [4:0]   rotAmount;
  armPkg::wordT imm8Word;
  logic [63:0]  imm8Doubled;
  armPkg::wordT rotImm;

  // Rotate right by twice the 4-bit rotate field
  assign rotAmount   = {instr[11:8], 1'b0};
  assign imm8Word    = {24'd0, instr[7:0]};
  // Doubling the word turns the right shift into a rotate
  assign imm8Doubled = {imm8Word, imm8Word} >> rotAmount;
  assign rotImm      = imm8Doubled[31:0];

  always_comb begin
    case (immSrc)
      armPkg::immData: begin
        ext = rotImm;
      end
      armPkg::immMem: begin
        // 12-bit load/store offset
        if (signExtend) begin
          ext = {{20{instr[11]}}, instr[11:0]};
        end else begin
          ext = {20'd0, instr[11:0]};
        end
      end
      armPkg::immBranch: begin
        // Word offset, scaled to bytes
        ext = {{6{instr[23]}}, instr[23:0], 2'b00};
      end
      default: begin
        ext = '0;
      end
    endcase
  end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
  input  armPkg::wordT  a,
  input  armPkg::wordT  b,
  input  armPkg::aluOpT op,
  input  logic          carryIn,
  output armPkg::wordT  result,
  output armPkg::flagsT flags
);

  armPkg::wordT bOperand;
  logic [32:0]  sum;
  logic         isArith;
  logic         carryOut;
  logic         overflow;
  logic         zeroRef;

  // Subtract is a plus inverted b plus one
  assign bOperand = (op == armPkg::aluSub) ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, bOperand} + {32'd0, (op == armPkg::aluSub)};
  assign isArith  = (op == armPkg::aluAdd) || (op == armPkg::aluSub);

  // Same input signs, different result sign
  assign overflow = (a[31] == bOperand[31]) && (sum[31] != a[31]);
  // Logical ops keep the incoming carry
  assign carryOut = isArith ? sum[32] : carryIn;

  always_comb begin
    case (op)
      armPkg::aluAdd: result = sum[31:0];
      armPkg::aluSub: result = sum[31:0];
      armPkg::aluAnd: result = a & b;
      armPkg::aluOrr: result = a | b;
      armPkg::aluEor: result = a ^ b;
      armPkg::aluMov: result = b;
      default:        result = '0;
    endcase
  end

  // N Z C V
  assign flags = {result[31], (result == '0), carryOut, isArith & overflow};

  // Zero expected from the operands alone
  always_comb begin
    case (op)
      armPkg::aluAdd: zeroRef = (a == (~b + 32'd1));
      armPkg::aluSub: zeroRef = (a == b);
      armPkg::aluAnd: zeroRef = ((a & b) == '0);
      armPkg::aluOrr: zeroRef = (a == '0) && (b == '0);
      armPkg::aluEor: zeroRef = (a == b);
      armPkg::aluMov: zeroRef = (b == '0);
      default:        zeroRef = 1'b1;
    endcase
  end

  // Zero flag agrees with the operand-level expectation
  always_comb begin
    assert (flags[2] == zeroRef)
      else $error("alu: Z flag disagrees with operands a %h b %h", a, b);
  end

endmodule

/* hdl/loadAlign.sv */
`timescale 1ns/1ps

module loadAlign (
  input  armPkg::wordT raw,
  input  logic [1:0]   byteOffset,
  input  logic         loadByte,
  input  logic         loadHalfword,
  input  logic         signedLoad,
  output armPkg::wordT data
);

  logic [7:0]  pickedByte;
  logic [15:0] pickedHalf;

  // Lane select, little endian
  assign pickedByte = raw[byteOffset*8 +: 8];
  // Upper half when offset bit 1 is set
  assign pickedHalf = byteOffset[1] ? raw[31:16] : raw[15:0];

  always_comb begin
    if (loadByte) begin
      data = {{24{signedLoad & pickedByte[7]}}, pickedByte};
    end else if (loadHalfword) begin
      data = {{16{signedLoad & pickedHalf[15]}}, pickedHalf};
    end else begin
      data = raw;
    end
  end

endmodule

/* hdl/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
  input  logic         clk,
  input  armPkg::wordT addr,
  input  armPkg::wordT wd,
  input  logic         we,
  input  logic [3:0]   byteEnable,
  output armPkg::wordT rd
);

  localparam int unsigned indexBits = $clog2(armPkg::memDepthWords);

  armPkg::wordT           mem [0:armPkg::memDepthWords-1];
  logic [indexBits-1:0]   wordIndex;

  // Byte address to word index
  assign wordIndex = addr[indexBits+1:2];

  // Lane-wise write
  always_ff @(posedge clk) begin
    if (we) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEnable[lane]) begin
          mem[wordIndex][lane*8 +: 8] <= wd[lane*8 +: 8];
        end
      end
    end
  end

  // Asynchronous read
  assign rd = mem[wordIndex];

  // A store always touches at least one lane
  assert property (@(posedge clk) we |-> (byteEnable != 4'b0000))
    else $error("dataMemory: write with no byte lanes enabled");

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath (
  input  logic             clk,
  input  logic             reset,
  input  armPkg::wordT     instrF,
  input  armPkg::wordT     readDataM,
  output armPkg::wordT     pcF,
  input  armPkg::immSrcT   immSrcD,
  input  logic             signExtendD,
  input  armPkg::regAddrT  ra1D,
  input  armPkg::regAddrT  ra2D,
  input  armPkg::regAddrT  wa3W,
  input  logic             aluSrcE,
  input  logic             incrementE,
  input  logic             branchTakenE,
  input  logic             carryInE,
  input  logic             writeByteE,
  input  logic             writeHalfwordE,
  input  armPkg::aluOpT    aluOpE,
  input  armPkg::fwdSelT   forwardAE,
  input  armPkg::fwdSelT   forwardBE,
  input  logic             pcSrcW,
  input  logic             regWriteW,
  input  logic             memToRegW,
  input  logic             psrToRegW,
  input  logic             loadByteW,
  input  logic             loadHalfwordW,
  input  logic             signedLoadW,
  input  armPkg::wordT     psrW,
  input  logic             exceptionSelectW,
  input  armPkg::wordT     vectorPcF,
  input  logic             stallF,
  input  logic             stallD,
  input  logic             flushD,
  input  logic             stallE,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushW,
  output armPkg::wordT     instrD,
  output armPkg::wordT     aluResultE,
  output armPkg::wordT     aluOutM,
  output armPkg::wordT     writeDataM,
  output armPkg::wordT     resultW,
  output armPkg::flagsT    aluFlagsE
);

  armPkg::wordT pcPlus4F, pcNextF;
  armPkg::wordT rd1D, rd2D, immD;
  armPkg::wordT rd1E, rd2E, immE;
  armPkg::wordT srcAE, writeDataE, srcBRegImmE, srcBE, writeDataReplE;
  armPkg::wordT aluOutW, readDataRawW, readDataW;

  // ============================================================
  // Fetch
  // ============================================================
  assign pcPlus4F = pcF + armPkg::pcStep;

  // Exception beats branch beats PC write from writeback
  always_comb begin
    if (exceptionSelectW) begin
      pcNextF = vectorPcF;
    end else if (branchTakenE) begin
      pcNextF = aluResultE;
    end else if (pcSrcW) begin
      pcNextF = resultW;
    end else begin
      pcNextF = pcPlus4F;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= armPkg::pcResetValue;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // PC must hold while fetch is stalled
  assert property (@(posedge clk) disable iff (reset) stallF |=> $stable(pcF))
    else $error("datapath: pcF moved during stallF");

  // ============================================================
  // Decode
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // Fetch PC+4 is decode PC+8 for r15 reads
  regFile regFile_i (
    .clk     (clk),
    .we      (regWriteW),
    .ra1     (ra1D),
    .ra2     (ra2D),
    .wa      (wa3W),
    .wd      (resultW),
    .pcValue (pcPlus4F),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  immExtend immExtend_i (
    .instr      (instrD),
    .immSrc     (immSrcD),
    .signExtend (signExtendD),
    .ext        (immD)
  );

  // ============================================================
  // Execute
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      rd1E <= '0;
      rd2E <= '0;
      immE <= '0;
    end else if (!stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= immD;
    end
  end

  // Operand bypass from later stages
  always_comb begin
    case (forwardAE)
      armPkg::fwdResultW: srcAE = resultW;
      armPkg::fwdAluOutM: srcAE = aluOutM;
      default:            srcAE = rd1E;
    endcase
    case (forwardBE)
      armPkg::fwdResultW: writeDataE = resultW;
      armPkg::fwdAluOutM: writeDataE = aluOutM;
      default:            writeDataE = rd2E;
    endcase
  end

  // Immediate, then the constant 4 for PC-relative increments
  assign srcBRegImmE = aluSrcE ? immE : writeDataE;
  assign srcBE       = incrementE ? armPkg::pcStep : srcBRegImmE;

  alu alu_i (
    .a       (srcAE),
    .b       (srcBE),
    .op      (aluOpE),
    .carryIn (carryInE),
    .result  (aluResultE),
    .flags   (aluFlagsE)
  );

  // Store data copied into every lane the store might hit
  always_comb begin
    if (writeByteE) begin
      writeDataReplE = {4{writeDataE[7:0]}};
    end else if (writeHalfwordE) begin
      writeDataReplE = {2{writeDataE[15:0]}};
    end else begin
      writeDataReplE = writeDataE;
    end
  end

  // ============================================================
  // Memory
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      aluOutM    <= '0;
      writeDataM <= '0;
    end else if (!stallM) begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataReplE;
    end
  end

  // ============================================================
  // Writeback
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      aluOutW      <= '0;
      readDataRawW <= '0;
    end else if (!stallW) begin
      aluOutW      <= aluOutM;
      readDataRawW <= readDataM;
    end
  end

  // Byte offset comes from the load address
  loadAlign loadAlign_i (
    .raw          (readDataRawW),
    .byteOffset   (aluOutW[1:0]),
    .loadByte     (loadByteW),
    .loadHalfword (loadHalfwordW),
    .signedLoad   (signedLoadW),
    .data         (readDataW)
  );

  // PSR read wins over load data
  always_comb begin
    if (psrToRegW) begin
      resultW = psrW;
    end else if (memToRegW) begin
      resultW = readDataW;
    end else begin
      resultW = aluOutW;
    end
  end

endmodule

/* hdl/datapathTop.sv */
`timescale 1ns/1ps

module datapathTop (
  input  logic             clk,
  input  logic             reset,
  input  armPkg::wordT     instrF,
  output armPkg::wordT     pcF,
  input  armPkg::immSrcT   immSrcD,
  input  logic             signExtendD,
  input  armPkg::regAddrT  ra1D,
  input  armPkg::regAddrT  ra2D,
  input  armPkg::regAddrT  wa3W,
  input  logic             aluSrcE,
  input  logic             incrementE,
  input  logic             branchTakenE,
  input  logic             carryInE,
  input  logic             writeByteE,
  input  logic             writeHalfwordE,
  input  armPkg::aluOpT    aluOpE,
  input  armPkg::fwdSelT   forwardAE,
  input  armPkg::fwdSelT   forwardBE,
  input  logic             pcSrcW,
  input  logic             regWriteW,
  input  logic             memToRegW,
  input  logic             psrToRegW,
  input  logic             loadByteW,
  input  logic             loadHalfwordW,
  input  logic             signedLoadW,
  input  armPkg::wordT     psrW,
  input  logic             exceptionSelectW,
  input  armPkg::wordT     vectorPcF,
  input  logic             stallF,
  input  logic             stallD,
  input  logic             flushD,
  input  logic             stallE,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushW,
  input  logic             memWriteM,
  input  logic [3:0]       byteEnableM,
  output armPkg::wordT     instrD,
  output armPkg::wordT     aluResultE,
  output armPkg::wordT     aluOutM,
  output armPkg::wordT     writeDataM,
  output armPkg::wordT     resultW,
  output armPkg::flagsT    aluFlagsE
);

  // Load data from the RAM into the writeback register
  armPkg::wordT readDataM;

  datapath datapath_i (
    .clk              (clk),
    .reset            (reset),
    .instrF           (instrF),
    .readDataM        (readDataM),
    .pcF              (pcF),
    .immSrcD          (immSrcD),
    .signExtendD      (signExtendD),
    .ra1D             (ra1D),
    .ra2D             (ra2D),
    .wa3W             (wa3W),
    .aluSrcE          (aluSrcE),
    .incrementE       (incrementE),
    .branchTakenE     (branchTakenE),
    .carryInE         (carryInE),
    .writeByteE       (writeByteE),
    .writeHalfwordE   (writeHalfwordE),
    .aluOpE           (aluOpE),
    .forwardAE        (forwardAE),
    .forwardBE        (forwardBE),
    .pcSrcW           (pcSrcW),
    .regWriteW        (regWriteW),
    .memToRegW        (memToRegW),
    .psrToRegW        (psrToRegW),
    .loadByteW        (loadByteW),
    .loadHalfwordW    (loadHalfwordW),
    .signedLoadW      (signedLoadW),
    .psrW             (psrW),
    .exceptionSelectW (exceptionSelectW),
    .vectorPcF        (vectorPcF),
    .stallF           (stallF),
    .stallD           (stallD),
    .flushD           (flushD),
    .stallE           (stallE),
    .stallM           (stallM),
    .stallW           (stallW),
    .flushW           (flushW),
    .instrD           (instrD),
    .aluResultE       (aluResultE),
    .aluOutM          (aluOutM),
    .writeDataM       (writeDataM),
    .resultW          (resultW),
    .aluFlagsE        (aluFlagsE)
  );

  // Memory stage address and replicated store data
  dataMemory dataMemory_i (
    .clk        (clk),
    .addr       (aluOutM),
    .wd         (writeDataM),
    .we         (memWriteM),
    .byteEnable (byteEnableM),
    .rd         (readDataM)
  );

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held high for the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* dv/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;

  // ============================================================
  // One instruction per row
  // ============================================================
  typedef struct {
    armPkg::wordT    instr;
    armPkg::immSrcT  immSrc;
    logic            signExt;
    armPkg::regAddrT ra1;
    armPkg::regAddrT ra2;
    logic            aluSrc;
    logic            incr;
    logic            branch;
    logic            carryIn;
    logic            wByte;
    logic            wHalf;
    armPkg::aluOpT   op;
    armPkg::fwdSelT  fwdA;
    armPkg::fwdSelT  fwdB;
    logic            memWrite;
    logic [3:0]      be;
    logic            stallF;
    logic            regWrite;
    armPkg::regAddrT wa3;
    logic            memToReg;
    logic            loadByte;
    logic            loadHalf;
    logic            signedLoad;
    logic            psrToReg;
    armPkg::wordT    psr;
    logic            flushW;
    logic            pcRel;
    armPkg::wordT    expAlu;
    armPkg::flagsT   expFlags;
    armPkg::wordT    expRes;
    armPkg::wordT    expWd;
  } rowT;

  logic clk;
  logic reset;

  armPkg::wordT    instrF, psrW, vectorPcF;
  armPkg::immSrcT  immSrcD;
  armPkg::regAddrT ra1D, ra2D, wa3W;
  armPkg::aluOpT   aluOpE;
  armPkg::fwdSelT  forwardAE, forwardBE;
  logic signExtendD, aluSrcE, incrementE, branchTakenE, carryInE;
  logic writeByteE, writeHalfwordE;
  logic pcSrcW, regWriteW, memToRegW, psrToRegW, loadByteW, loadHalfwordW, signedLoadW;
  logic exceptionSelectW, stallF, stallD, flushD, stallE, stallM, stallW, flushW;
  logic memWriteM;
  logic [3:0] byteEnableM;
  armPkg::wordT  pcF, instrD, aluResultE, aluOutM, writeDataM, resultW;
  armPkg::flagsT aluFlagsE;

  rowT          rows[$];
  armPkg::wordT shadow [0:63];
  logic [15:0]  lfsrState = 16'd81;
  logic         tableReady = 1'b0;
  int           errors = 0;
  int           checks = 0;

  // Fetch PC model
  armPkg::wordT expPc;
  logic         curStallF;
  logic         curBranch;
  armPkg::wordT curTarget;

  clockGen clockGen_i (
    .clk   (clk),
    .reset (reset)
  );

  datapathTop datapathTop_i (
    .clk(clk), .reset(reset), .instrF(instrF), .pcF(pcF),
    .immSrcD(immSrcD), .signExtendD(signExtendD),
    .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
    .aluSrcE(aluSrcE), .incrementE(incrementE), .branchTakenE(branchTakenE),
    .carryInE(carryInE), .writeByteE(writeByteE), .writeHalfwordE(writeHalfwordE),
    .aluOpE(aluOpE), .forwardAE(forwardAE), .forwardBE(forwardBE),
    .pcSrcW(pcSrcW), .regWriteW(regWriteW), .memToRegW(memToRegW),
    .psrToRegW(psrToRegW), .loadByteW(loadByteW), .loadHalfwordW(loadHalfwordW),
    .signedLoadW(signedLoadW), .psrW(psrW), .exceptionSelectW(exceptionSelectW),
    .vectorPcF(vectorPcF), .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .stallE(stallE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .memWriteM(memWriteM), .byteEnableM(byteEnableM),
    .instrD(instrD), .aluResultE(aluResultE), .aluOutM(aluOutM),
    .writeDataM(writeDataM), .resultW(resultW), .aluFlagsE(aluFlagsE)
  );

  // ============================================================
  // Stimulus helpers
  // ============================================================

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit
  function automatic armPkg::wordT randomWord();
    armPkg::wordT w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[30:0], lfsrState[0]};
    end
    return w;
  endfunction

  function automatic rowT blankRow();
    rowT r;
    r = '{default: '0};
    return r;
  endfunction

  // Move of an immediate with flags from the value and carry-in low
  function automatic rowT movRow(armPkg::wordT instr, armPkg::immSrcT src, logic sx,
                                 armPkg::wordT value);
    rowT r;
    r = blankRow();
    r.instr = instr;
    r.immSrc = src;
    r.signExt = sx;
    r.aluSrc = 1'b1;
    r.op = armPkg::aluMov;
    r.expAlu = value;
    r.expRes = value;
    r.expFlags = {value[31], (value == 32'd0), 2'b00};
    return r;
  endfunction

  // Register A against a data-processing immediate
  function automatic rowT opRow(armPkg::aluOpT op, armPkg::regAddrT ra1,
                                armPkg::wordT instr, armPkg::wordT value,
                                armPkg::flagsT flags);
    rowT r;
    r = blankRow();
    r.instr = instr;
    r.immSrc = armPkg::immData;
    r.ra1 = ra1;
    r.aluSrc = 1'b1;
    r.op = op;
    r.expAlu = value;
    r.expRes = value;
    r.expFlags = flags;
    return r;
  endfunction

  function automatic rowT withWrite(rowT r, armPkg::regAddrT wa);
    r.regWrite = 1'b1;
    r.wa3 = wa;
    return r;
  endfunction

  function automatic rowT psrRow(armPkg::wordT value);
    rowT r;
    r = movRow(32'd0, armPkg::immData, 1'b0, 32'd0);
    r.psrToReg = 1'b1;
    r.psr = value;
    r.expRes = value;
    return r;
  endfunction

  // Kind 0 word, 1 halfword, 2 byte
  function automatic rowT storeRow(logic [7:0] addr, armPkg::regAddrT src, int kind,
                                   armPkg::wordT data);
    rowT r;
    armPkg::wordT lanes;
    r = movRow({24'd0, addr}, armPkg::immMem, 1'b0, {24'd0, addr});
    r.ra2 = src;
    r.memWrite = 1'b1;
    if (kind == 2) begin
      r.wByte = 1'b1;
      r.be = 4'b0001 << addr[1:0];
      lanes = {4{data[7:0]}};
    end else if (kind == 1) begin
      r.wHalf = 1'b1;
      r.be = addr[1] ? 4'b1100 : 4'b0011;
      lanes = {2{data[15:0]}};
    end else begin
      r.be = 4'b1111;
      lanes = data;
    end
    r.expWd = lanes;
    // Shadow copy of the RAM
    for (int lane = 0; lane < 4; lane++) begin
      if (r.be[lane]) begin
        shadow[addr[7:2]][lane*8 +: 8] = lanes[lane*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic rowT loadRow(logic [7:0] addr, int kind, logic sgn);
    rowT r;
    armPkg::wordT w;
    logic [15:0] h;
    logic [7:0] b;
    r = movRow({24'd0, addr}, armPkg::immMem, 1'b0, {24'd0, addr});
    r.memToReg = 1'b1;
    r.loadByte = (kind == 2);
    r.loadHalf = (kind == 1);
    r.signedLoad = sgn;
    w = shadow[addr[7:2]];
    h = addr[1] ? w[31:16] : w[15:0];
    b = w[addr[1:0]*8 +: 8];
    if (kind == 2) begin
      r.expRes = {{24{sgn & b[7]}}, b};
    end else if (kind == 1) begin
      r.expRes = {{16{sgn & h[15]}}, h};
    end else begin
      r.expRes = w;
    end
    return r;
  endfunction

  // ============================================================
  // Table
  // ============================================================
  task automatic buildTable();
    rowT r;
    armPkg::wordT d5, d6, d7;
    // Operand registers r1 r2 r3
    rows.push_back(withWrite(movRow(32'h0FF, armPkg::immData, 1'b0, 32'h0000_00FF), 1));
    rows.push_back(withWrite(movRow(32'h102, armPkg::immData, 1'b0, 32'h8000_0000), 2));
    rows.push_back(withWrite(movRow(32'h47F, armPkg::immData, 1'b0, 32'h7F00_0000), 3));
    rows.push_back(movRow(32'd0, armPkg::immData, 1'b0, 32'd0));
    // ALU ops and flags
    rows.push_back(opRow(armPkg::aluAdd, 1, 32'h001, 32'h0000_0100, 4'b0000));
    rows.push_back(opRow(armPkg::aluSub, 1, 32'h0FF, 32'h0000_0000, 4'b0110));
    rows.push_back(opRow(armPkg::aluAdd, 2, 32'h102, 32'h0000_0000, 4'b0111));
    rows.push_back(opRow(armPkg::aluAdd, 3, 32'h47F, 32'hFE00_0000, 4'b1001));
    rows.push_back(opRow(armPkg::aluSub, 1, 32'hC01, 32'hFFFF_FFFF, 4'b1000));
    r = opRow(armPkg::aluAnd, 1, 32'h00F, 32'h0000_000F, 4'b0010);
    r.carryIn = 1'b1;
    rows.push_back(r);
    rows.push_back(opRow(armPkg::aluOrr, 2, 32'h0FF, 32'h8000_00FF, 4'b1000));
    rows.push_back(opRow(armPkg::aluEor, 1, 32'h0FF, 32'h0000_0000, 4'b0100));
    // Memory and branch immediate forms
    rows.push_back(movRow(32'h800, armPkg::immMem, 1'b1, 32'hFFFF_F800));
    rows.push_back(movRow(32'h800, armPkg::immMem, 1'b0, 32'h0000_0800));
    rows.push_back(movRow(32'h00FF_FFFF, armPkg::immBranch, 1'b0, 32'hFFFF_FFFC));
    r = opRow(armPkg::aluAdd, 1, 32'h0, 32'h0000_0103, 4'b0000);
    r.incr = 1'b1;
    rows.push_back(r);
    // Forwarding of r4 from memory, writeback, then the register file
    rows.push_back(withWrite(movRow(32'h055, armPkg::immData, 1'b0, 32'h55), 4));
    r = opRow(armPkg::aluAdd, 4, 32'h001, 32'h56, 4'b0000);
    r.fwdA = armPkg::fwdAluOutM;
    rows.push_back(r);
    r.fwdA = armPkg::fwdResultW;
    rows.push_back(r);
    rows.push_back(movRow(32'd0, armPkg::immData, 1'b0, 32'd0));
    rows.push_back(opRow(armPkg::aluAdd, 4, 32'h001, 32'h56, 4'b0000));
    // Fetch stall for three cycles, then a branch to 0x40
    for (int i = 0; i < 3; i++) begin
      r = movRow(32'd0, armPkg::immData, 1'b0, 32'd0);
      r.stallF = 1'b1;
      rows.push_back(r);
    end
    r = movRow(32'h040, armPkg::immData, 1'b0, 32'h40);
    r.branch = 1'b1;
    rows.push_back(r);
    // r15 reads as decode PC+8 and the value is filled in while running
    r = opRow(armPkg::aluAdd, armPkg::pcIndex, 32'h0, 32'h0, 4'b0000);
    r.pcRel = 1'b1;
    rows.push_back(r);
    // Random store data through the PSR path
    d5 = randomWord();
    d6 = randomWord();
    d7 = randomWord();
    rows.push_back(withWrite(psrRow(d5), 5));
    rows.push_back(withWrite(psrRow(d6), 6));
    rows.push_back(withWrite(psrRow(d7), 7));
    rows.push_back(movRow(32'd0, armPkg::immData, 1'b0, 32'd0));
    rows.push_back(storeRow(8'h20, 5, 0, d5));
    rows.push_back(storeRow(8'h24, 6, 1, d6));
    rows.push_back(storeRow(8'h26, 6, 1, d6));
    for (int k = 0; k < 4; k++) begin
      rows.push_back(storeRow(8'h28 + k[7:0], 7, 2, d7));
    end
    // Loads of every width and offset
    rows.push_back(loadRow(8'h20, 0, 1'b0));
    rows.push_back(loadRow(8'h24, 1, 1'b0));
    rows.push_back(loadRow(8'h26, 1, 1'b1));
    rows.push_back(loadRow(8'h24, 1, 1'b1));
    rows.push_back(loadRow(8'h26, 1, 1'b0));
    for (int k = 0; k < 4; k++) begin
      rows.push_back(loadRow(8'h20 + k[7:0], 2, k[0]));
      rows.push_back(loadRow(8'h20 + k[7:0], 2, !k[0]));
      rows.push_back(loadRow(8'h28 + k[7:0], 2, k[0]));
    end
    // PSR onto the result, then a writeback flush
    rows.push_back(psrRow(randomWord()));
    r = movRow(32'h033, armPkg::immData, 1'b0, 32'h33);
    r.flushW = 1'b1;
    rows.push_back(r);
    r = movRow(32'h044, armPkg::immData, 1'b0, 32'h44);
    r.expRes = 32'd0;
    rows.push_back(r);
    rows.push_back(movRow(32'd0, armPkg::immData, 1'b0, 32'd0));
  endtask

  function automatic rowT rowAt(int i);
    if (i >= 0 && i < rows.size()) begin
      return rows[i];
    end
    return blankRow();
  endfunction

  task automatic checkValue(string name, armPkg::wordT exp, armPkg::wordT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Each stage gets the row that is in it this cycle
  task automatic driveStages(int c);
    rowT f, d, e, m, w;
    if (c >= 1 && c - 1 < rows.size() && rows[c-1].pcRel) begin
      rows[c-1].expAlu = expPc + armPkg::pcStep;
      rows[c-1].expRes = expPc + armPkg::pcStep;
    end
    f = rowAt(c);
    d = rowAt(c - 1);
    e = rowAt(c - 2);
    m = rowAt(c - 3);
    w = rowAt(c - 4);
    instrF <= f.instr;
    stallF <= f.stallF;
    immSrcD <= d.immSrc;
    signExtendD <= d.signExt;
    ra1D <= d.ra1;
    ra2D <= d.ra2;
    aluSrcE <= e.aluSrc;
    incrementE <= e.incr;
    branchTakenE <= e.branch;
    carryInE <= e.carryIn;
    writeByteE <= e.wByte;
    writeHalfwordE <= e.wHalf;
    aluOpE <= e.op;
    forwardAE <= e.fwdA;
    forwardBE <= e.fwdB;
    memWriteM <= m.memWrite;
    byteEnableM <= m.be;
    regWriteW <= w.regWrite;
    wa3W <= w.wa3;
    memToRegW <= w.memToReg;
    psrToRegW <= w.psrToReg;
    loadByteW <= w.loadByte;
    loadHalfwordW <= w.loadHalf;
    signedLoadW <= w.signedLoad;
    psrW <= w.psr;
    flushW <= w.flushW;
    curStallF = f.stallF;
    curBranch = e.branch;
    curTarget = e.expAlu;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    {instrF, psrW, vectorPcF, immSrcD, ra1D, ra2D, wa3W, aluOpE} = '0;
    {forwardAE, forwardBE, signExtendD, aluSrcE, incrementE, branchTakenE} = '0;
    {carryInE, writeByteE, writeHalfwordE, pcSrcW, regWriteW, memToRegW} = '0;
    {psrToRegW, loadByteW, loadHalfwordW, signedLoadW, exceptionSelectW} = '0;
    {stallF, stallD, flushD, stallE, stallM, stallW, flushW} = '0;
    memWriteM = 1'b0;
    byteEnableM = 4'b0000;
    expPc = armPkg::pcResetValue;
    curStallF = 1'b0;
    curBranch = 1'b0;
    curTarget = '0;
    buildTable();
    tableReady = 1'b1;

    do @(negedge clk); while (reset);
    checkValue("pcF", armPkg::pcResetValue, pcF);

    for (int c = 0; c < rows.size() + 4; c++) begin
      @(posedge clk);
      // PC the edge just loaded
      if (!curStallF) begin
        if (curBranch) begin
          expPc = curTarget;
        end else begin
          expPc = expPc + armPkg::pcStep;
        end
      end
      driveStages(c);
      @(negedge clk);
      checkValue("pcF", expPc, pcF);
      if (c - 1 >= 0 && c - 1 < rows.size()) begin
        checkValue("instrD", rows[c-1].instr, instrD);
      end
      if (c - 2 >= 0 && c - 2 < rows.size()) begin
        checkValue("aluResultE", rows[c-2].expAlu, aluResultE);
        checkValue("aluFlagsE", {28'd0, rows[c-2].expFlags}, {28'd0, aluFlagsE});
      end
      if (c - 3 >= 0 && c - 3 < rows.size()) begin
        checkValue("aluOutM", rows[c-3].expAlu, aluOutM);
        if (rows[c-3].memWrite) begin
          checkValue("writeDataM", rows[c-3].expWd, writeDataM);
        end
      end
      if (c - 4 >= 0) begin
        checkValue("resultW", rows[c-4].expRes, resultW);
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog over the row count plus 20 cycles
  initial begin
    wait (tableReady);
    repeat (rows.size() + 20) @(posedge clk);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("** FAIL **");
    $finish;
  end

endmodule

/* all.f */
hdl/armPkg.sv
hdl/regFile.sv
hdl/immExtend.sv
hdl/alu.sv
hdl/loadAlign.sv
hdl/dataMemory.sv
hdl/datapath.sv
hdl/datapathTop.sv
dv/clockGen.sv
dv/datapathTb.sv

/* run.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module datapathTb -o datapathSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/datapathSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF "** PASS **"; then
  exit 0
fi
exit 1
